//--- build.f
verilog/mem_io_pkg.sv
verilog/mem_io_ram.sv
verilog/mem_io_decode.sv
verilog/mem_io_execute.sv
verilog/mem_io_result.sv
verilog/mem_io_top.sv
sim/mem_io_properties.sv
sim/mem_io_tb.sv

//--- Bender.yml
package:
  name: mem_io

sources:
  - verilog/mem_io_pkg.sv
  - verilog/mem_io_ram.sv
  - verilog/mem_io_decode.sv
  - verilog/mem_io_execute.sv
  - verilog/mem_io_result.sv
  - verilog/mem_io_top.sv
  - target: simulation
    files:
      - sim/mem_io_properties.sv
      - sim/mem_io_tb.sv

//--- sim/mem_io_tb.sv
// ------------------------------
// Testbench for the word store
// Clock, reset, APB driver tasks and compare tasks
// Directed tests for RAM, address zero and both I/O windows
// ------------------------------

`timescale 1ns/10ps

module mem_io_tb;

    localparam int ready_timeout = 20;

    logic                                  clock;
    logic                                  rst_n;
    mem_io_pkg::apb_req_t                  apb;
    mem_io_pkg::apb_rsp_t                  apb_rsp;
    logic                                  io_ready;
    mem_io_pkg::io_read_bus_t              io_read_data;
    mem_io_pkg::io_write_bus_t             io_write_data;
    logic [mem_io_pkg::io_write_count-1:0] io_wren;

    // Expected contents of the output register bank
    mem_io_pkg::io_write_bus_t             out_model;
    int                                    wren_pulses;

    mem_io_top mem_io_top_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .apb           (apb),
        .apb_rsp       (apb_rsp),
        .io_ready      (io_ready),
        .io_read_data  (io_read_data),
        .io_write_data (io_write_data),
        .io_wren       (io_wren)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // Counts every cycle with an output write enable at the falling edge
    always @(negedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wren_pulses <= 0;
        end else if (io_wren != '0) begin
            wren_pulses <= wren_pulses + 1;
        end
    end

    // ------------------------------
    // Compare tasks

    task automatic check_word(input string name, input mem_io_pkg::word_t expected,
                              input mem_io_pkg::word_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_error(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_wren(input string name,
                              input logic [mem_io_pkg::io_write_count-1:0] expected,
                              input logic [mem_io_pkg::io_write_count-1:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "io_wren mismatch");
        end
    endtask

    // ------------------------------
    // Bound assertion failures

    task automatic report_assertion_failure();
        $display("A bound assertion in mem_io_properties failed");
        $display("TB FAILED");
        $fatal(1, "assertion failure");
    endtask

    // Any counted assertion failure stops the run at the next falling edge
    always @(negedge clock) begin
        if (mem_io_top_i.props_i.failures != 0) begin
            report_assertion_failure();
        end
    end

    // ------------------------------
    // APB driver tasks start 2 ns after a rising edge and return at the same offset

    // Responses are sampled on the falling edge away from any register update
    task automatic wait_for_pready(input string caller);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (apb_rsp.pready !== 1'b1) begin
            cycles++;
            if (cycles > ready_timeout) begin
                $display("Timeout in %s: pready never rose", caller);
                $display("TB FAILED");
                $fatal(1, "pready timeout");
            end
            @(negedge clock);
        end
    endtask

    task automatic start_transfer(input logic write, input mem_io_pkg::word_addr_t addr,
                                  input mem_io_pkg::word_t wdata);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = write;
        apb.paddr   = {addr, 2'b00};
        apb.pwdata  = wdata;
        @(posedge clock);
        #2 apb.penable = 1'b1;
    endtask

    task automatic end_transfer();
        @(posedge clock);
        #2 apb = '0;
    endtask

    task automatic apb_write(input mem_io_pkg::word_addr_t addr, input mem_io_pkg::word_t data,
                             output logic err,
                             output logic [mem_io_pkg::io_write_count-1:0] wren);
        start_transfer(1'b1, addr, data);
        wait_for_pready("apb_write");
        err  = apb_rsp.pslverr;
        wren = io_wren;
        end_transfer();
    endtask

    task automatic apb_read(input mem_io_pkg::word_addr_t addr, output mem_io_pkg::word_t data,
                            output logic err);
        start_transfer(1'b0, addr, '0);
        wait_for_pready("apb_read");
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        end_transfer();
    endtask

    // Every output register must match the model
    task automatic check_outputs(input string name);
        for (int i = 0; i < mem_io_pkg::io_write_count; i++) begin
            check_word(name, out_model[i], io_write_data[i]);
        end
    endtask

    // ------------------------------
    // Directed tests

    task automatic test_reset_state();
        @(negedge clock);
        check_error("reset_pready", 1'b0, apb_rsp.pready);
        check_error("reset_pslverr", 1'b0, apb_rsp.pslverr);
        check_word("reset_prdata", '0, apb_rsp.prdata);
        check_wren("reset_io_wren", '0, io_wren);
        check_outputs("reset_io_write_data");
        @(posedge clock);
        #2;
    endtask

    task automatic test_ram_round_trip();
        mem_io_pkg::word_addr_t addrs [12];
        mem_io_pkg::word_t      words [12];
        mem_io_pkg::word_t      rdata;
        logic                   err;
        logic [mem_io_pkg::io_write_count-1:0] wren;
        // One address per 16-word block keeps them distinct and below the windows
        for (int i = 0; i < 12; i++) begin
            addrs[i] = 8'(i * 16 + 1 + ($urandom % 15));
            words[i] = $urandom;
            apb_write(addrs[i], words[i], err, wren);
            check_error("ram_write_pslverr", 1'b0, err);
            check_wren("ram_write_io_wren", '0, wren);
        end
        for (int i = 0; i < 12; i++) begin
            apb_read(addrs[i], rdata, err);
            check_word("ram_read_data", words[i], rdata);
            check_error("ram_read_pslverr", 1'b0, err);
        end
    endtask

    task automatic test_address_zero();
        mem_io_pkg::word_t rdata;
        logic              err;
        logic [mem_io_pkg::io_write_count-1:0] wren;
        int                pulses_before;
        pulses_before = wren_pulses;
        apb_write(8'h00, 32'hDEAD_BEEF, err, wren);
        check_error("zero_write_pslverr", 1'b0, err);
        check_wren("zero_write_io_wren", '0, wren);
        apb_read(8'h00, rdata, err);
        check_word("zero_read_data", '0, rdata);
        check_error("zero_read_pslverr", 1'b0, err);
        check_word("zero_wren_pulses", pulses_before, wren_pulses);
    endtask

    task automatic test_output_registers();
        mem_io_pkg::word_t data;
        logic              err;
        logic [mem_io_pkg::io_write_count-1:0] wren;
        for (int i = 0; i < mem_io_pkg::io_write_count; i++) begin
            data = $urandom;
            apb_write(mem_io_pkg::io_write_base + 8'(i), data, err, wren);
            out_model[i] = data;
            check_error("out_write_pslverr", 1'b0, err);
            check_wren("out_write_io_wren", 4'(1 << i), wren);
            check_outputs("out_write_data");
        end
    endtask

    task automatic test_input_ports();
        mem_io_pkg::word_t expected [mem_io_pkg::io_read_count];
        mem_io_pkg::word_t rdata;
        logic              err;
        // Port number in the top byte keeps the values distinct
        for (int i = 0; i < mem_io_pkg::io_read_count; i++) begin
            expected[i]     = {8'hA0 + 8'(i), 24'($urandom)};
            io_read_data[i] = expected[i];
        end
        io_ready = 1'b1;
        for (int i = 0; i < mem_io_pkg::io_read_count; i++) begin
            apb_read(mem_io_pkg::io_read_base + 8'(i), rdata, err);
            check_word("in_read_ready", expected[i], rdata);
            check_error("in_read_pslverr", 1'b0, err);
        end
        io_ready = 1'b0;
        for (int i = 0; i < mem_io_pkg::io_read_count; i++) begin
            apb_read(mem_io_pkg::io_read_base + 8'(i), rdata, err);
            check_word("in_read_not_ready", '0, rdata);
        end
    endtask

    task automatic test_wrong_direction();
        mem_io_pkg::word_t rdata;
        logic              err;
        logic [mem_io_pkg::io_write_count-1:0] wren;
        int                pulses_before;
        pulses_before = wren_pulses;
        apb_write(mem_io_pkg::io_read_base + 8'd1, 32'h1234_5678, err, wren);
        check_error("bad_write_pslverr", 1'b1, err);
        check_wren("bad_write_io_wren", '0, wren);
        apb_read(mem_io_pkg::io_write_base + 8'd2, rdata, err);
        check_error("bad_read_pslverr", 1'b1, err);
        check_outputs("bad_access_outputs");
        check_word("bad_wren_pulses", pulses_before, wren_pulses);
    endtask

    // ------------------------------
    // Sequence

    initial begin
        apb          = '0;
        io_ready     = 1'b0;
        io_read_data = '0;
        out_model    = '0;
        rst_n        = 1'b0;
        void'($urandom(32'ha992_a0cf));
        repeat (3) @(posedge clock);
        #2 rst_n = 1'b1;

        test_reset_state();
        test_ram_round_trip();
        test_address_zero();
        test_output_registers();
        test_input_ports();
        test_wrong_direction();

        if (mem_io_top_i.props_i.failures != 0) begin
            report_assertion_failure();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- sim/mem_io_properties.sv
// ------------------------------
// Concurrent assertions for the word store
// APB response rules and output write enables
// Bound to mem_io_top
// ------------------------------

`timescale 1ns/10ps

module mem_io_properties (
    input logic                                    clock,
    input logic                                    rst_n,
    input mem_io_pkg::apb_req_t                    apb,
    input mem_io_pkg::apb_rsp_t                    apb_rsp,
    input logic [mem_io_pkg::io_write_count-1:0]   io_wren
);

    // Number of assertion failures seen so far
    int unsigned failures = 0;

    // pready may only end a transfer that is in its access phase
    ready_in_access: assert property (@(posedge clock) disable iff (!rst_n)
        apb_rsp.pready |-> (apb.psel && apb.penable))
        else begin
            $error("pready high outside an APB access phase");
            failures++;
        end

    // An error is only reported together with completion
    error_with_ready: assert property (@(posedge clock) disable iff (!rst_n)
        apb_rsp.pslverr |-> apb_rsp.pready)
        else begin
            $error("pslverr high without pready");
            failures++;
        end

    // At most one output register is written at a time
    wren_onehot: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(io_wren))
        else begin
            $error("more than one io_wren bit set");
            failures++;
        end

    // Each write enable is a single-cycle pulse
    wren_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        (io_wren != '0) |=> (io_wren == '0))
        else begin
            $error("io_wren held for more than one cycle");
            failures++;
        end

    // No output write right after reset is released
    wren_quiet_after_reset: assert property (@(posedge clock)
        $rose(rst_n) |-> (io_wren == '0))
        else begin
            $error("io_wren set in the cycle after reset release");
            failures++;
        end

endmodule

bind mem_io_top mem_io_properties props_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .apb     (apb),
    .apb_rsp (apb_rsp),
    .io_wren (io_wren)
);

//--- verilog/mem_io_top.sv
// ------------------------------
// Top level of the word store
// APB front end, execute stage and response stage
// ------------------------------

`timescale 1ns/10ps

module mem_io_top (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  mem_io_pkg::apb_req_t                    apb,
    output mem_io_pkg::apb_rsp_t                    apb_rsp,
    input  logic                                    io_ready,
    input  mem_io_pkg::io_read_bus_t                io_read_data,
    output mem_io_pkg::io_write_bus_t               io_write_data,
    output logic [mem_io_pkg::io_write_count-1:0]   io_wren
);

    mem_io_pkg::mem_access_t  access;
    mem_io_pkg::exec_result_t exec;

    // The completing cycle on the bus releases the front end
    mem_io_decode decode_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .apb      (apb),
        .rsp_done (apb_rsp.pready),
        .access   (access)
    );

    mem_io_execute execute_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .access        (access),
        .io_read_data  (io_read_data),
        .io_wren       (io_wren),
        .io_write_data (io_write_data),
        .exec          (exec)
    );

    mem_io_result result_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .exec     (exec),
        .io_ready (io_ready),
        .apb_rsp  (apb_rsp)
    );

endmodule

//--- verilog/mem_io_result.sv
// ------------------------------
// Read stage 2 and APB response
// Picks the read word, annuls it where needed
// and registers pready, pslverr and prdata
// ------------------------------

`timescale 1ns/10ps

module mem_io_result (
    input  logic                     clock,
    input  logic                     rst_n,
    input  mem_io_pkg::exec_result_t exec,
    input  logic                     io_ready,
    output mem_io_pkg::apb_rsp_t     apb_rsp
);

    mem_io_pkg::word_t    read_selected;
    mem_io_pkg::word_t    read_annulled;
    mem_io_pkg::apb_rsp_t rsp_q;

    // ------------------------------
    // Read word selection

    always_comb begin
        case (exec.source)
            mem_io_pkg::src_ram: read_selected = exec.ram_data;
            mem_io_pkg::src_io:  read_selected = exec.io_data;
            default:             read_selected = '0;
        endcase
    end

    // Ports that are not ready read as zero
    // Writes also leave prdata at zero
    assign read_annulled = (!exec.is_read ||
                            (exec.source == mem_io_pkg::src_io && !io_ready))
                           ? '0 : read_selected;

    // ------------------------------
    // Response register

    // pready is high for exactly the one cycle after done
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q <= '0;
        end else begin
            rsp_q.pready  <= exec.done;
            rsp_q.pslverr <= exec.done & exec.err;
            rsp_q.prdata  <= exec.done ? read_annulled : '0;
        end
    end

    assign apb_rsp = rsp_q;

endmodule

//--- verilog/mem_io_execute.sv
// ------------------------------
// Execute stage of the word store
// Read stage 1 and write stages 1 and 2
// RAM, input port select and output register bank
// ------------------------------

`timescale 1ns/10ps

module mem_io_execute (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  mem_io_pkg::mem_access_t                 access,
    input  mem_io_pkg::io_read_bus_t                io_read_data,
    output logic [mem_io_pkg::io_write_count-1:0]   io_wren,
    output mem_io_pkg::io_write_bus_t               io_write_data,
    output mem_io_pkg::exec_result_t                exec
);

    logic                                   ram_rden;
    mem_io_pkg::word_t                      ram_read_data;
    logic                                   rd_valid_q;
    logic                                   wr_valid_q;
    logic                                   err_q;
    mem_io_pkg::read_source_e               source_q;
    mem_io_pkg::word_t                      io_data_q;
    logic                                   mem_wren_s2;
    logic [mem_io_pkg::io_write_count-1:0]  io_wren_s2;
    mem_io_pkg::word_addr_t                 wr_addr_s2;
    mem_io_pkg::word_t                      wr_data_s2;
    logic                                   is_read_op;
    logic                                   is_write_op;

    // Directions of the classified access
    // A bad access is completed on the write side, it carries no read data
    assign is_read_op  = (access.op == mem_io_pkg::op_ram_read)  ||
                         (access.op == mem_io_pkg::op_zero_read) ||
                         (access.op == mem_io_pkg::op_io_read);
    assign is_write_op = (access.op == mem_io_pkg::op_ram_write)  ||
                         (access.op == mem_io_pkg::op_zero_write) ||
                         (access.op == mem_io_pkg::op_io_write)   ||
                         (access.op == mem_io_pkg::op_bad_access);

    // ------------------------------
    // Read stage 1

    // RAM is kept idle for address zero and the I/O windows
    assign ram_rden = (access.op == mem_io_pkg::op_ram_read);

    mem_io_ram ram_i (
        .clock      (clock),
        .wren       (mem_wren_s2),
        .write_addr (wr_addr_s2),
        .write_data (wr_data_s2),
        .rden       (ram_rden),
        .read_addr  (access.addr),
        .read_data  (ram_read_data)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
            err_q      <= 1'b0;
            source_q   <= mem_io_pkg::src_zero;
        end else begin
            rd_valid_q <= is_read_op;
            wr_valid_q <= is_write_op;
            err_q      <= (access.op == mem_io_pkg::op_bad_access);
            // Anything not read from RAM or a port returns zero
            case (access.op)
                mem_io_pkg::op_ram_read: source_q <= mem_io_pkg::src_ram;
                mem_io_pkg::op_io_read:  source_q <= mem_io_pkg::src_io;
                default:                 source_q <= mem_io_pkg::src_zero;
            endcase
        end
    end

    // Sampled port word, lined up with the RAM output
    always_ff @(posedge clock) begin
        if (access.op == mem_io_pkg::op_io_read) begin
            io_data_q <= io_read_data[access.index];
        end
    end

    // ------------------------------
    // Write stage 1, stage the write and decode the port enable

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mem_wren_s2 <= 1'b0;
            io_wren_s2  <= '0;
        end else begin
            mem_wren_s2 <= (access.op == mem_io_pkg::op_ram_write);
            io_wren_s2  <= '0;
            if (access.op == mem_io_pkg::op_io_write) begin
                io_wren_s2[access.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (is_write_op) begin
            wr_addr_s2 <= access.addr;
            wr_data_s2 <= access.data;
        end
    end

    // ------------------------------
    // Write stage 2, the RAM write happens inside ram_i

    // Only the addressed output register takes the new word
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            io_wren       <= '0;
            io_write_data <= '0;
        end else begin
            io_wren <= io_wren_s2;
            for (int i = 0; i < mem_io_pkg::io_write_count; i++) begin
                if (io_wren_s2[i]) begin
                    io_write_data[i] <= wr_data_s2;
                end
            end
        end
    end

    // Both directions report done in the same cycle, so every transfer
    // completes with the same two wait states
    always_comb begin
        exec.done     = rd_valid_q | wr_valid_q;
        exec.is_read  = rd_valid_q;
        exec.err      = err_q;
        exec.source   = source_q;
        exec.ram_data = ram_read_data;
        exec.io_data  = io_data_q;
    end

endmodule

//--- verilog/mem_io_decode.sv
// ------------------------------
// APB front end
// Tracks the setup phase and classifies the word address
// into one registered access request
// ------------------------------

`timescale 1ns/10ps

module mem_io_decode (
    input  logic                    clock,
    input  logic                    rst_n,
    input  mem_io_pkg::apb_req_t    apb,
    input  logic                    rsp_done,
    output mem_io_pkg::mem_access_t access
);

    mem_io_pkg::decode_state_e               state;
    mem_io_pkg::word_addr_t                  word_addr;
    mem_io_pkg::word_addr_t                  read_offset;
    mem_io_pkg::word_addr_t                  write_offset;
    logic                                    is_zero;
    logic                                    in_read_window;
    logic                                    in_write_window;
    logic                                    setup;
    mem_io_pkg::access_op_e                  op_next;
    logic [mem_io_pkg::io_index_width-1:0]   index_next;
    mem_io_pkg::access_op_e                  op_q;
    mem_io_pkg::word_addr_t                  addr_q;
    logic [mem_io_pkg::io_index_width-1:0]   index_q;
    mem_io_pkg::word_t                       data_q;

    // ------------------------------
    // Address classification

    // The byte address carries two unused low bits
    assign word_addr    = apb.paddr[mem_io_pkg::apb_addr_width-1:2];
    assign read_offset  = word_addr - mem_io_pkg::io_read_base;
    assign write_offset = word_addr - mem_io_pkg::io_write_base;

    assign is_zero         = (word_addr == '0);
    assign in_read_window  = (word_addr >= mem_io_pkg::io_read_base) &&
                             (word_addr <  mem_io_pkg::io_read_base + mem_io_pkg::io_read_count);
    assign in_write_window = (word_addr >= mem_io_pkg::io_write_base) &&
                             (word_addr <  mem_io_pkg::io_write_base + mem_io_pkg::io_write_count);

    // A setup phase is only taken while no transfer is in flight
    assign setup = (state == mem_io_pkg::st_idle) && apb.psel && !apb.penable;

    always_comb begin
        if (is_zero) begin
            op_next = apb.pwrite ? mem_io_pkg::op_zero_write : mem_io_pkg::op_zero_read;
        end else if (in_read_window) begin
            // Input ports cannot be written
            op_next = apb.pwrite ? mem_io_pkg::op_bad_access : mem_io_pkg::op_io_read;
        end else if (in_write_window) begin
            // Output registers cannot be read back
            op_next = apb.pwrite ? mem_io_pkg::op_io_write : mem_io_pkg::op_bad_access;
        end else begin
            op_next = apb.pwrite ? mem_io_pkg::op_ram_write : mem_io_pkg::op_ram_read;
        end
    end

    // Port index inside whichever window was hit, don't care for RAM accesses
    assign index_next = in_write_window ? write_offset[mem_io_pkg::io_index_width-1:0]
                                        : read_offset[mem_io_pkg::io_index_width-1:0];

    // ------------------------------
    // FSM, the opcode is a one-cycle pulse at the end of setup

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_io_pkg::st_idle;
            op_q  <= mem_io_pkg::op_none;
        end else begin
            op_q <= mem_io_pkg::op_none;
            case (state)
                mem_io_pkg::st_idle: begin
                    if (setup) begin
                        state <= mem_io_pkg::st_busy;
                        op_q  <= op_next;
                    end
                end
                default: begin
                    // Completion seen on the bus frees the front end
                    if (rsp_done) begin
                        state <= mem_io_pkg::st_idle;
                    end
                end
            endcase
        end
    end

    // Payload travels beside the opcode
    always_ff @(posedge clock) begin
        if (setup) begin
            addr_q  <= word_addr;
            index_q <= index_next;
            data_q  <= apb.pwdata;
        end
    end

    always_comb begin
        access.op    = op_q;
        access.addr  = addr_q;
        access.index = index_q;
        access.data  = data_q;
    end

endmodule

//--- verilog/mem_io_ram.sv
// ------------------------------
// Simple dual-port word RAM
// One write port, one read port with enable
// ------------------------------

`timescale 1ns/10ps

module mem_io_ram (
    input  logic                   clock,
    input  logic                   wren,
    input  mem_io_pkg::word_addr_t write_addr,
    input  mem_io_pkg::word_t      write_data,
    input  logic                   rden,
    input  mem_io_pkg::word_addr_t read_addr,
    output mem_io_pkg::word_t      read_data
);

    // Storage, one word per address
    mem_io_pkg::word_t mem [mem_io_pkg::mem_depth];

    // ------------------------------
    // Write port

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // ------------------------------
    // Read port

    // One cycle of latency
    // The output holds its last word while rden is low, so a disabled
    // read costs no array access
    always_ff @(posedge clock) begin
        if (rden) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

//--- verilog/mem_io_pkg.sv
// ------------------------------
// Shared definitions for the memory-mapped word store
// Sizes and address windows as localparams
// APB request and response structs
// Access opcodes, FSM states and pipeline structs
// ------------------------------

package mem_io_pkg;

    // Sizes of the data word and the word address space
    localparam int word_width     = 32;
    localparam int addr_width     = 8;
    localparam int apb_addr_width = addr_width + 2;
    localparam int mem_depth      = 256;

    typedef logic [word_width-1:0] word_t;
    typedef logic [addr_width-1:0] word_addr_t;

    // ------------------------------
    // I/O windows, both kept clear of address zero
    localparam int         io_read_count   = 4;
    localparam word_addr_t io_read_base    = 8'hF0;
    localparam int         io_write_count  = 4;
    localparam word_addr_t io_write_base   = 8'hF8;
    localparam int         io_index_width  = 2;

    typedef word_t [io_read_count-1:0]  io_read_bus_t;
    typedef word_t [io_write_count-1:0] io_write_bus_t;

    // ------------------------------
    // APB signals, split by which side drives them
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [apb_addr_width-1:0] paddr;
        word_t                     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        logic  pslverr;
        word_t prdata;
    } apb_rsp_t;

    // ------------------------------
    // op_none must stay at encoding zero, it is the idle value after reset
    typedef enum logic [2:0] {
        op_none,
        op_ram_read,
        op_ram_write,
        op_zero_read,
        op_zero_write,
        op_io_read,
        op_io_write,
        op_bad_access
    } access_op_e;

    typedef enum logic {
        st_idle,
        st_busy
    } decode_state_e;

    typedef enum logic [1:0] {
        src_ram,
        src_io,
        src_zero
    } read_source_e;

    // One classified access, valid for a single cycle
    typedef struct packed {
        access_op_e                op;
        word_addr_t                addr;
        logic [io_index_width-1:0] index;
        word_t                     data;
    } mem_access_t;

    // What the execute stage hands to the response stage
    typedef struct packed {
        logic         done;
        logic         is_read;
        logic         err;
        read_source_e source;
        word_t        ram_data;
        word_t        io_data;
    } exec_result_t;

endpackage
